// ==== flist.f ====
source/redmule_pkg.sv
source/redmule_ctrl.sv
source/redmule_stream_reader.sv
source/redmule_mem_arbiter.sv
source/redmule_engine.sv
source/redmule_z_writer.sv
source/redmule_top.sv
sim/tb_clock_gen.sv
sim/tb_redmule.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_redmule -f flist.f || exit 1
sim_out="$(./obj_dir/Vtb_redmule)"
echo "$sim_out"
echo "$sim_out" | grep -qx "TB PASSED" && exit 0 || exit 1

// ==== sim/tb_clock_gen.sv ====
module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset held for 16 rising edges, released on a falling edge
  initial begin
    rst_o = 1'b1;
    repeat (16) @(posedge clk_o);
    @(negedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

// ==== sim/tb_redmule.sv ====
module tb_redmule;
  import redmule_pkg::*;

  localparam int CFG_TIMEOUT = 50;
  localparam int JOB_TIMEOUT = 4000;
  localparam int RUN_LIMIT   = 200000;

  logic                  clk_i;
  logic                  rst_i;
  logic                  cfg_req_i;
  logic                  cfg_we_i;
  logic [CFG_ADDR_W-1:0] cfg_addr_i;
  logic [31:0]           cfg_wdata_i;
  logic                  cfg_ack_o;
  logic [31:0]           cfg_rdata_o;
  logic                  busy_o;
  logic                  done_o;
  logic                  mem_req_o;
  logic                  mem_we_o;
  logic [ADDR_W-1:0]     mem_addr_o;
  logic [WORD_W-1:0]     mem_wdata_o;
  logic                  mem_ack_i   = 1'b0;
  logic [WORD_W-1:0]     mem_rdata_i = '0;

  logic [63:0] mem [0:255];
  logic [63:0] exp_row [4];
  logic [31:0] data_lfsr;
  logic [31:0] lat_lfsr  = 32'h8f16ecfd;
  int unsigned lat_left  = 0;
  logic        lat_armed = 1'b0;

  int   errors       = 0;
  int   checks       = 0;
  int   proto_errors = 0;
  int   done_count   = 0;
  int   tests_run    = 0;
  int   tests_failed = 0;
  logic run_done     = 1'b0;
  logic timed_out    = 1'b0;

  logic              prev_req = 1'b0;
  logic              prev_ack = 1'b0;
  logic              prev_we;
  logic [ADDR_W-1:0] prev_addr;
  logic [WORD_W-1:0] prev_wdata;

  tb_clock_gen i_clock_gen (
    .clk_o ( clk_i ),
    .rst_o ( rst_i )
  );

  redmule_top dut0 (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .cfg_req_i   ( cfg_req_i   ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg_ack_o   ( cfg_ack_o   ),
    .cfg_rdata_o ( cfg_rdata_o ),
    .busy_o      ( busy_o      ),
    .done_o      ( done_o      ),
    .mem_req_o   ( mem_req_o   ),
    .mem_we_o    ( mem_we_o    ),
    .mem_addr_o  ( mem_addr_o  ),
    .mem_wdata_o ( mem_wdata_o ),
    .mem_ack_i   ( mem_ack_i   ),
    .mem_rdata_i ( mem_rdata_i )
  );

  // Galois LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int b = 0; b < n; b++) begin
      val[b] = data_lfsr[0];
      data_lfsr = lfsr_step(data_lfsr);
    end
  endtask

  task automatic random_word(output logic [63:0] w);
    logic [31:0] lo;
    logic [31:0] hi;
    draw_bits(32, lo);
    draw_bits(32, hi);
    w = {hi, lo};
  endtask

  function automatic logic [63:0] word_at(input int a);
    return mem[a[7:0]];
  endfunction

  task automatic put_word(input int a, input logic [63:0] v);
    mem[a[7:0]] = v;
  endtask

  // Memory model, four-phase with 0 to 3 cycles of latency
  always @(negedge clk_i) begin
    if (rst_i) begin
      mem_ack_i <= 1'b0;
      lat_armed = 1'b0;
    end else if (mem_ack_i) begin
      if (!mem_req_o) begin
        mem_ack_i <= 1'b0;
      end
    end else if (mem_req_o) begin
      if (!lat_armed) begin
        lat_left  = {31'd0, lat_lfsr[0]};
        lat_lfsr  = lfsr_step(lat_lfsr);
        lat_left  = lat_left + (lat_lfsr[0] ? 2 : 0);
        lat_lfsr  = lfsr_step(lat_lfsr);
        lat_armed = 1'b1;
      end
      if (lat_left == 0) begin
        if (mem_we_o) begin
          mem[mem_addr_o[7:0]] = mem_wdata_o;
        end else begin
          mem_rdata_i <= mem[mem_addr_o[7:0]];
        end
        mem_ack_i <= 1'b1;
        lat_armed = 1'b0;
      end else begin
        lat_left = lat_left - 1;
      end
    end
  end

  // Memory handshake rules, checked on every rising edge
  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (prev_req && !mem_req_o) begin
        assert (prev_ack) else begin
          $display("FAIL %0t: mem_req_o fell before mem_ack_i rose", $time);
          proto_errors++;
          errors++;
        end
      end
      if (!prev_req && mem_req_o) begin
        assert (!prev_ack) else begin
          $display("FAIL %0t: mem_req_o rose while mem_ack_i was high", $time);
          proto_errors++;
          errors++;
        end
      end
      if (prev_req && mem_req_o) begin
        assert (mem_addr_o == prev_addr && mem_wdata_o == prev_wdata && mem_we_o == prev_we)
        else begin
          $display("FAIL %0t: memory request changed while mem_req_o was high", $time);
          proto_errors++;
          errors++;
        end
      end
    end
    prev_req   = mem_req_o;
    prev_ack   = mem_ack_i;
    prev_we    = mem_we_o;
    prev_addr  = mem_addr_o;
    prev_wdata = mem_wdata_o;
    if (done_o) begin
      done_count++;
    end
  end

  task automatic give_up(input string what);
    $display("Timeout at %0t: %s", $time, what);
    timed_out = 1'b1;
    forever @(negedge clk_i);
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic cfg_access(input logic we, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int n;
    @(negedge clk_i);
    cfg_req_i   <= 1'b1;
    cfg_we_i    <= we;
    cfg_addr_i  <= addr;
    cfg_wdata_i <= wdata;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!cfg_ack_o && n < CFG_TIMEOUT);
    if (!cfg_ack_o) begin
      give_up("configuration port never raised ack");
    end
    rdata = cfg_rdata_o;
    cfg_req_i <= 1'b0;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (cfg_ack_o && n < CFG_TIMEOUT);
    if (cfg_ack_o) begin
      give_up("configuration port never dropped ack");
    end
  endtask

  task automatic cfg_write(input logic [7:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    cfg_access(1'b1, addr, wdata, unused);
  endtask

  task automatic cfg_read(input logic [7:0] addr, output logic [31:0] rdata);
    cfg_access(1'b0, addr, '0, rdata);
  endtask

  task automatic configure_job(input int xb, input int wb, input int yb, input int zb,
                               input int k);
    cfg_write(REG_X_BASE, xb);
    cfg_write(REG_W_BASE, wb);
    cfg_write(REG_Y_BASE, yb);
    cfg_write(REG_Z_BASE, zb);
    cfg_write(REG_K_DEPTH, k);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy_o && n < JOB_TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (busy_o) begin
      give_up("job never finished");
    end
    // Gives the monitor time to see the done pulse
    repeat (2) @(negedge clk_i);
  endtask

  task automatic fill_random(input int xb, input int wb, input int yb, input int k);
    logic [63:0] w;
    for (int kk = 0; kk < k; kk++) begin
      random_word(w);
      put_word(xb + kk, w);
      random_word(w);
      put_word(wb + kk, w);
    end
    for (int i = 0; i < 4; i++) begin
      random_word(w);
      put_word(yb + i, w);
    end
  endtask

  // Z = X*W + Y with X stored by column, W by row, all mod 2^16
  task automatic compute_expected(input int xb, input int wb, input int yb, input int k);
    logic [63:0] xw;
    logic [63:0] ww;
    logic [63:0] yw;
    logic [15:0] acc;
    for (int i = 0; i < 4; i++) begin
      yw = word_at(yb + i);
      for (int j = 0; j < 4; j++) begin
        acc = yw[16*j +: 16];
        for (int kk = 0; kk < k; kk++) begin
          xw  = word_at(xb + kk);
          ww  = word_at(wb + kk);
          acc = acc + xw[16*i +: 16] * ww[16*j +: 16];
        end
        exp_row[i][16*j +: 16] = acc;
      end
    end
  endtask

  task automatic check_tile(input int zb, input string label);
    for (int i = 0; i < 4; i++) begin
      check_value(word_at(zb + i), exp_row[i], $sformatf("%s Z row %0d", label, i));
    end
  endtask

  task automatic end_test(input string name, input int failures);
    tests_run++;
    if (failures == 0) begin
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d failing checks", name, failures);
    end
  endtask

  initial begin
    int          n;
    int          err0;
    int          dc;
    int          k;
    logic [31:0] r;
    logic [63:0] w;
    logic [63:0] alt [4];
    cfg_req_i   = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    data_lfsr   = 32'h8f16ecfd;
    for (int a = 0; a < 256; a++) begin
      put_word(a, {4{a[7:0] ^ 8'h3c, a[7:0]}});
    end

    n = 0;
    while (rst_i && n < 100) begin
      @(negedge clk_i);
      n++;
    end
    if (rst_i) begin
      give_up("reset was never released");
    end

    err0 = errors;
    check_value(busy_o, 0, "busy_o after reset");
    check_value(done_o, 0, "done_o after reset");
    check_value(mem_req_o, 0, "mem_req_o after reset");
    check_value(cfg_ack_o, 0, "cfg_ack_o after reset");
    end_test("reset", errors - err0);

    err0 = errors;
    configure_job(32'h1234, 32'hbeef, 32'h00a5, 32'h5a00, 32'h7f);
    cfg_read(REG_X_BASE, r);
    check_value(r, 32'h1234, "X base readback");
    cfg_read(REG_W_BASE, r);
    check_value(r, 32'hbeef, "W base readback");
    cfg_read(REG_Y_BASE, r);
    check_value(r, 32'h00a5, "Y base readback");
    cfg_read(REG_Z_BASE, r);
    check_value(r, 32'h5a00, "Z base readback");
    cfg_read(REG_K_DEPTH, r);
    check_value(r, 32'h7f, "K readback");
    cfg_read(REG_STATUS, r);
    check_value(r, 0, "STATUS while idle");
    end_test("register readback", errors - err0);

    // Lanes hold wrapping cases, Z[0][1] and Z[3][3] worked out by hand
    err0 = errors;
    put_word(4, {16'd4, 16'd3, 16'd2, 16'd1});
    put_word(5, {16'h8000, 16'd300, 16'hffff, 16'd7});
    for (int i = 0; i < 4; i++) begin
      put_word(8 + i, {16'h0001, 16'h1000, 16'hfff0, 16'(i)});
    end
    compute_expected(4, 5, 8, 1);
    configure_job(4, 5, 8, 12, 1);
    dc = done_count;
    cfg_write(REG_TRIGGER, 1);
    wait_idle();
    check_value(done_count - dc, 1, "done pulses in fixed job");
    check_tile(12, "fixed job");
    w = word_at(12);
    check_value(w[31:16], 16'hffef, "fixed job Z[0][1]");
    w = word_at(15);
    check_value(w[63:48], 16'h0001, "fixed job Z[3][3]");
    end_test("fixed job", errors - err0);

    for (int j = 0; j < 3; j++) begin
      err0 = errors;
      draw_bits(3, r);
      k = int'(r[2:0]) + 1;
      fill_random(32'h10 + 8 * j, 32'h30 + 8 * j, 32'h80 + 8 * j, k);
      compute_expected(32'h10 + 8 * j, 32'h30 + 8 * j, 32'h80 + 8 * j, k);
      configure_job(32'h10 + 8 * j, 32'h30 + 8 * j, 32'h80 + 8 * j, 32'ha0 + 8 * j, k);
      dc = done_count;
      cfg_write(REG_TRIGGER, 1);
      wait_idle();
      check_value(done_count - dc, 1, "done pulses in random job");
      check_tile(32'ha0 + 8 * j, $sformatf("random job %0d", j));
      end_test($sformatf("random job %0d with K=%0d", j, k), errors - err0);
    end

    // Second trigger and a new Z base arrive while the job runs
    err0 = errors;
    fill_random(32'h20, 32'h40, 32'h60, 8);
    compute_expected(32'h20, 32'h40, 32'h60, 8);
    for (int i = 0; i < 4; i++) begin
      alt[i] = word_at(32'hc0 + i);
    end
    configure_job(32'h20, 32'h40, 32'h60, 32'h70, 8);
    dc = done_count;
    cfg_write(REG_TRIGGER, 1);
    cfg_read(REG_STATUS, r);
    check_value(r[0], 1, "STATUS busy bit during job");
    cfg_write(REG_Z_BASE, 32'hc0);
    cfg_write(REG_TRIGGER, 1);
    cfg_read(REG_Z_BASE, r);
    check_value(r, 32'h70, "Z base after write while busy");
    wait_idle();
    check_value(done_count - dc, 1, "done pulses in busy test");
    check_tile(32'h70, "busy test");
    for (int i = 0; i < 4; i++) begin
      check_value(word_at(32'hc0 + i), alt[i], $sformatf("untouched word %0d", i));
    end
    end_test("busy behavior", errors - err0);

    end_test("memory protocol", proto_errors);
    run_done = 1'b1;
  end

  initial begin
    int n;
    n = 0;
    while (!run_done && !timed_out && n < RUN_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (!run_done && !timed_out) begin
      $display("Simulation ran past its cycle limit of %0d", RUN_LIMIT);
    end
    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (!run_done || timed_out || errors != 0) begin
      $display("TB FAILED");
    end else begin
      $display("TB PASSED");
    end
    $finish;
  end

endmodule

// ==== source/redmule_ctrl.sv ====
module redmule_ctrl (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               cfg_req_i,
  input  logic                               cfg_we_i,
  input  logic [redmule_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
  input  logic [31:0]                        cfg_wdata_i,
  output logic                               cfg_ack_o,
  output logic [31:0]                        cfg_rdata_o,
  input  logic                               z_done_i,
  output logic                               start_o,
  output logic [redmule_pkg::ADDR_W-1:0]     x_base_o,
  output logic [redmule_pkg::ADDR_W-1:0]     w_base_o,
  output logic [redmule_pkg::ADDR_W-1:0]     y_base_o,
  output logic [redmule_pkg::ADDR_W-1:0]     z_base_o,
  output logic [redmule_pkg::CNT_W-1:0]      k_depth_o,
  output logic                               busy_o,
  output logic                               done_o
);
  import redmule_pkg::*;

  logic [ADDR_W-1:0] x_base_q;
  logic [ADDR_W-1:0] w_base_q;
  logic [ADDR_W-1:0] y_base_q;
  logic [ADDR_W-1:0] z_base_q;
  logic [CNT_W-1:0]  k_depth_q;
  logic [31:0]       rdata_q;
  logic              ack_q;
  logic              busy_q;
  logic              done_q;
  logic              start_q;
  logic              access;
  logic              wr_en;
  logic              trigger;

  // A new access is seen on the first cycle of req
  assign access  = cfg_req_i && !ack_q;
  // Register writes are locked out for the whole job
  assign wr_en   = access && cfg_we_i && !busy_q;
  assign trigger = wr_en && (cfg_addr_i == REG_TRIGGER);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q     <= 1'b0;
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      start_q   <= 1'b0;
      x_base_q  <= '0;
      w_base_q  <= '0;
      y_base_q  <= '0;
      z_base_q  <= '0;
      k_depth_q <= '0;
    end else begin
      // Ack follows req with one cycle of delay on both edges
      ack_q   <= cfg_req_i;
      start_q <= trigger;
      done_q  <= busy_q && z_done_i;
      if (trigger) begin
        busy_q <= 1'b1;
      end else if (z_done_i) begin
        busy_q <= 1'b0;
      end
      if (wr_en) begin
        case (cfg_addr_i)
          REG_X_BASE:  x_base_q  <= cfg_wdata_i[ADDR_W-1:0];
          REG_W_BASE:  w_base_q  <= cfg_wdata_i[ADDR_W-1:0];
          REG_Y_BASE:  y_base_q  <= cfg_wdata_i[ADDR_W-1:0];
          REG_Z_BASE:  z_base_q  <= cfg_wdata_i[ADDR_W-1:0];
          REG_K_DEPTH: k_depth_q <= cfg_wdata_i[CNT_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // Read data is sampled together with the rising ack
  always_ff @(posedge clk_i) begin
    if (access && !cfg_we_i) begin
      case (cfg_addr_i)
        REG_X_BASE:  rdata_q <= 32'(x_base_q);
        REG_W_BASE:  rdata_q <= 32'(w_base_q);
        REG_Y_BASE:  rdata_q <= 32'(y_base_q);
        REG_Z_BASE:  rdata_q <= 32'(z_base_q);
        REG_K_DEPTH: rdata_q <= 32'(k_depth_q);
        REG_STATUS:  rdata_q <= {31'd0, busy_q};
        default:     rdata_q <= '0;
      endcase
    end
  end

  assign cfg_ack_o   = ack_q;
  assign cfg_rdata_o = rdata_q;
  assign start_o     = start_q;
  assign busy_o      = busy_q;
  assign done_o      = done_q;
  assign x_base_o    = x_base_q;
  assign w_base_o    = w_base_q;
  assign y_base_o    = y_base_q;
  assign z_base_o    = z_base_q;
  assign k_depth_o   = k_depth_q;

endmodule

// ==== source/redmule_engine.sv ====
module redmule_engine (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          start_i,
  input  logic [redmule_pkg::CNT_W-1:0] k_depth_i,
  input  redmule_pkg::mem_word_u        y_i,
  input  redmule_pkg::mem_word_u        x_i,
  input  redmule_pkg::mem_word_u        w_i,
  input  logic                          y_valid_i,
  input  logic                          x_valid_i,
  input  logic                          w_valid_i,
  input  logic                          z_ready_i,
  output logic                          y_ready_o,
  output logic                          x_ready_o,
  output logic                          w_ready_o,
  output redmule_pkg::mem_word_u        z_row_o,
  output logic                          z_valid_o
);
  import redmule_pkg::*;

  logic [LANES-1:0][LANES-1:0][ELEM_W-1:0] acc_q;
  logic [1:0]                              phase_q;
  logic [$clog2(LANES)-1:0]                row_q;
  logic [CNT_W-1:0]                        step_q;
  logic [CNT_W-1:0]                        k_q;
  logic                                    step_en;

  // X and W are consumed together, one outer product per step
  assign step_en   = (phase_q == PH_ACC) && x_valid_i && w_valid_i;
  assign y_ready_o = (phase_q == PH_LOAD);
  assign x_ready_o = (phase_q == PH_ACC) && w_valid_i;
  assign w_ready_o = (phase_q == PH_ACC) && x_valid_i;
  assign z_valid_o = (phase_q == PH_DRAIN);
  assign z_row_o.lane = acc_q[row_q];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      phase_q <= PH_IDLE;
      row_q   <= '0;
      step_q  <= '0;
      k_q     <= '0;
    end else if (start_i) begin
      phase_q <= PH_LOAD;
      row_q   <= '0;
      step_q  <= '0;
      k_q     <= k_depth_i;
    end else begin
      case (phase_q)
        PH_LOAD: if (y_valid_i) begin
          row_q <= row_q + 1'b1;
          if (row_q == $clog2(LANES)'(LANES - 1)) begin
            phase_q <= PH_ACC;
          end
        end
        PH_ACC: if (step_en) begin
          step_q <= step_q + 1'b1;
          if (step_q == k_q - 1'b1) begin
            phase_q <= PH_DRAIN;
          end
        end
        PH_DRAIN: if (z_ready_i) begin
          row_q <= row_q + 1'b1;
          if (row_q == $clog2(LANES)'(LANES - 1)) begin
            phase_q <= PH_IDLE;
          end
        end
        default: ;
      endcase
    end
  end

  // Accumulator array, wrapping 16-bit arithmetic
  always_ff @(posedge clk_i) begin
    if ((phase_q == PH_LOAD) && y_valid_i) begin
      acc_q[row_q] <= y_i.lane;
    end else if (step_en) begin
      for (int i = 0; i < LANES; i++) begin
        for (int j = 0; j < LANES; j++) begin
          acc_q[i][j] <= acc_q[i][j] + x_i.lane[i] * w_i.lane[j];
        end
      end
    end
  end

endmodule

// ==== source/redmule_mem_arbiter.sv ====
module redmule_mem_arbiter (
  input  logic                                                   clk_i,
  input  logic                                                   rst_i,
  input  logic [redmule_pkg::N_CLIENTS-1:0]                      cl_req_i,
  input  logic [redmule_pkg::N_CLIENTS-1:0]                      cl_we_i,
  input  logic [redmule_pkg::N_CLIENTS-1:0][redmule_pkg::ADDR_W-1:0] cl_addr_i,
  input  redmule_pkg::mem_word_u [redmule_pkg::N_CLIENTS-1:0]    cl_wdata_i,
  output logic [redmule_pkg::N_CLIENTS-1:0]                      cl_ack_o,
  output logic [redmule_pkg::WORD_W-1:0]                         cl_rdata_o,
  output logic                                                   mem_req_o,
  output logic                                                   mem_we_o,
  output logic [redmule_pkg::ADDR_W-1:0]                         mem_addr_o,
  output logic [redmule_pkg::WORD_W-1:0]                         mem_wdata_o,
  input  logic                                                   mem_ack_i,
  input  logic [redmule_pkg::WORD_W-1:0]                         mem_rdata_i
);
  import redmule_pkg::*;

  logic             busy_q;
  logic [GNT_W-1:0] gnt_q;
  logic [GNT_W-1:0] pick;

  // Lowest requesting index wins
  always_comb begin
    pick = '0;
    for (int i = N_CLIENTS - 1; i >= 0; i--) begin
      if (cl_req_i[i]) begin
        pick = GNT_W'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      gnt_q  <= '0;
    end else if (!busy_q) begin
      if (|cl_req_i) begin
        busy_q <= 1'b1;
        gnt_q  <= pick;
      end
    end else if (!cl_req_i[gnt_q] && !mem_ack_i) begin
      // Grant is released only after the full four-phase cycle
      busy_q <= 1'b0;
    end
  end

  always_comb begin
    cl_ack_o        = '0;
    cl_ack_o[gnt_q] = busy_q && mem_ack_i;
  end

  assign mem_req_o   = busy_q && cl_req_i[gnt_q];
  assign mem_we_o    = cl_we_i[gnt_q];
  assign mem_addr_o  = cl_addr_i[gnt_q];
  assign mem_wdata_o = cl_wdata_i[gnt_q].raw;
  assign cl_rdata_o  = mem_rdata_i;

endmodule

// ==== source/redmule_pkg.sv ====
package redmule_pkg;

  // Datapath geometry
  localparam int unsigned ELEM_W = 16;
  localparam int unsigned LANES  = 4;
  localparam int unsigned WORD_W = ELEM_W * LANES;
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned CNT_W  = 8;

  // Configuration port register map, byte offsets
  localparam int unsigned CFG_ADDR_W = 8;
  localparam logic [CFG_ADDR_W-1:0] REG_X_BASE  = 8'h00;
  localparam logic [CFG_ADDR_W-1:0] REG_W_BASE  = 8'h04;
  localparam logic [CFG_ADDR_W-1:0] REG_Y_BASE  = 8'h08;
  localparam logic [CFG_ADDR_W-1:0] REG_Z_BASE  = 8'h0C;
  localparam logic [CFG_ADDR_W-1:0] REG_K_DEPTH = 8'h10;
  localparam logic [CFG_ADDR_W-1:0] REG_TRIGGER = 8'h14;
  localparam logic [CFG_ADDR_W-1:0] REG_STATUS  = 8'h18;

  // Memory arbiter clients, lower index wins
  localparam int unsigned N_CLIENTS = 4;
  localparam int unsigned GNT_W     = $clog2(N_CLIENTS);
  localparam int unsigned CL_Z      = 0;
  localparam int unsigned CL_W      = 1;
  localparam int unsigned CL_X      = 2;
  localparam int unsigned CL_Y      = 3;

  // Engine phases
  localparam logic [1:0] PH_IDLE  = 2'd0;
  localparam logic [1:0] PH_LOAD  = 2'd1;
  localparam logic [1:0] PH_ACC   = 2'd2;
  localparam logic [1:0] PH_DRAIN = 2'd3;

  // One memory word, seen whole or as four elements
  typedef union packed {
    logic [WORD_W-1:0]            raw;
    logic [LANES-1:0][ELEM_W-1:0] lane;
  } mem_word_u;

endpackage

// ==== source/redmule_stream_reader.sv ====
module redmule_stream_reader (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           start_i,
  input  logic [redmule_pkg::ADDR_W-1:0] base_i,
  input  logic [redmule_pkg::CNT_W-1:0]  count_i,
  input  logic                           req_ack_i,
  input  logic [redmule_pkg::WORD_W-1:0] rdata_i,
  input  logic                           ready_i,
  output logic                           req_o,
  output logic [redmule_pkg::ADDR_W-1:0] addr_o,
  output logic [redmule_pkg::WORD_W-1:0] data_o,
  output logic                           valid_o
);
  import redmule_pkg::*;

  logic [ADDR_W-1:0] addr_q;
  logic [CNT_W-1:0]  left_q;
  logic [WORD_W-1:0] data_q;
  logic              req_q;
  logic              drop_q;
  logic              valid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_q   <= 1'b0;
      drop_q  <= 1'b0;
      valid_q <= 1'b0;
      addr_q  <= '0;
      left_q  <= '0;
    end else if (start_i) begin
      addr_q <= base_i;
      left_q <= count_i;
      req_q  <= (count_i != '0);
    end else begin
      if (req_q && req_ack_i) begin
        req_q  <= 1'b0;
        drop_q <= 1'b1;
      end
      // Word is offered only once the memory has closed the handshake
      if (drop_q && !req_ack_i) begin
        drop_q  <= 1'b0;
        valid_q <= 1'b1;
      end
      if (valid_q && ready_i) begin
        valid_q <= 1'b0;
        left_q  <= left_q - 1'b1;
        addr_q  <= addr_q + 1'b1;
        req_q   <= (left_q != CNT_W'(1));
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_q && req_ack_i) begin
      data_q <= rdata_i;
    end
  end

  assign req_o   = req_q;
  assign addr_o  = addr_q;
  assign data_o  = data_q;
  assign valid_o = valid_q;

endmodule

// ==== source/redmule_top.sv ====
module redmule_top (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              cfg_req_i,
  input  logic                              cfg_we_i,
  input  logic [redmule_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
  input  logic [31:0]                       cfg_wdata_i,
  output logic                              cfg_ack_o,
  output logic [31:0]                       cfg_rdata_o,
  output logic                              busy_o,
  output logic                              done_o,
  output logic                              mem_req_o,
  output logic                              mem_we_o,
  output logic [redmule_pkg::ADDR_W-1:0]    mem_addr_o,
  output logic [redmule_pkg::WORD_W-1:0]    mem_wdata_o,
  input  logic                              mem_ack_i,
  input  logic [redmule_pkg::WORD_W-1:0]    mem_rdata_i
);
  import redmule_pkg::*;

  logic                              start;
  logic                              z_done;
  logic [ADDR_W-1:0]                 x_base;
  logic [ADDR_W-1:0]                 w_base;
  logic [ADDR_W-1:0]                 y_base;
  logic [ADDR_W-1:0]                 z_base;
  logic [CNT_W-1:0]                  k_depth;

  logic [N_CLIENTS-1:0]              cl_req;
  logic [N_CLIENTS-1:0]              cl_ack;
  logic [N_CLIENTS-1:0]              cl_we;
  logic [N_CLIENTS-1:0][ADDR_W-1:0]  cl_addr;
  mem_word_u [N_CLIENTS-1:0]         cl_wdata;
  logic [WORD_W-1:0]                 cl_rdata;

  mem_word_u                         x_word;
  mem_word_u                         w_word;
  mem_word_u                         y_word;
  mem_word_u                         z_row;
  logic                              x_valid;
  logic                              w_valid;
  logic                              y_valid;
  logic                              z_valid;
  logic                              x_ready;
  logic                              w_ready;
  logic                              y_ready;
  logic                              z_ready;

  // Only the Z writer stores to memory
  assign cl_we[CL_Z]          = 1'b1;
  assign cl_we[CL_W]          = 1'b0;
  assign cl_we[CL_X]          = 1'b0;
  assign cl_we[CL_Y]          = 1'b0;
  assign cl_wdata[CL_W].raw   = '0;
  assign cl_wdata[CL_X].raw   = '0;
  assign cl_wdata[CL_Y].raw   = '0;

  redmule_ctrl i_ctrl (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .cfg_req_i   ( cfg_req_i   ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg_ack_o   ( cfg_ack_o   ),
    .cfg_rdata_o ( cfg_rdata_o ),
    .z_done_i    ( z_done      ),
    .start_o     ( start       ),
    .x_base_o    ( x_base      ),
    .w_base_o    ( w_base      ),
    .y_base_o    ( y_base      ),
    .z_base_o    ( z_base      ),
    .k_depth_o   ( k_depth     ),
    .busy_o      ( busy_o      ),
    .done_o      ( done_o      )
  );

  redmule_stream_reader i_x_reader (
    .clk_i     ( clk_i         ),
    .rst_i     ( rst_i         ),
    .start_i   ( start         ),
    .base_i    ( x_base        ),
    .count_i   ( k_depth       ),
    .req_ack_i ( cl_ack[CL_X]  ),
    .rdata_i   ( cl_rdata      ),
    .ready_i   ( x_ready       ),
    .req_o     ( cl_req[CL_X]  ),
    .addr_o    ( cl_addr[CL_X] ),
    .data_o    ( x_word.raw    ),
    .valid_o   ( x_valid       )
  );

  redmule_stream_reader i_w_reader (
    .clk_i     ( clk_i         ),
    .rst_i     ( rst_i         ),
    .start_i   ( start         ),
    .base_i    ( w_base        ),
    .count_i   ( k_depth       ),
    .req_ack_i ( cl_ack[CL_W]  ),
    .rdata_i   ( cl_rdata      ),
    .ready_i   ( w_ready       ),
    .req_o     ( cl_req[CL_W]  ),
    .addr_o    ( cl_addr[CL_W] ),
    .data_o    ( w_word.raw    ),
    .valid_o   ( w_valid       )
  );

  // Y is always one full tile of row words
  redmule_stream_reader i_y_reader (
    .clk_i     ( clk_i          ),
    .rst_i     ( rst_i          ),
    .start_i   ( start          ),
    .base_i    ( y_base         ),
    .count_i   ( CNT_W'(LANES)  ),
    .req_ack_i ( cl_ack[CL_Y]   ),
    .rdata_i   ( cl_rdata       ),
    .ready_i   ( y_ready        ),
    .req_o     ( cl_req[CL_Y]   ),
    .addr_o    ( cl_addr[CL_Y]  ),
    .data_o    ( y_word.raw     ),
    .valid_o   ( y_valid        )
  );

  redmule_engine i_engine (
    .clk_i     ( clk_i   ),
    .rst_i     ( rst_i   ),
    .start_i   ( start   ),
    .k_depth_i ( k_depth ),
    .y_i       ( y_word  ),
    .x_i       ( x_word  ),
    .w_i       ( w_word  ),
    .y_valid_i ( y_valid ),
    .x_valid_i ( x_valid ),
    .w_valid_i ( w_valid ),
    .z_ready_i ( z_ready ),
    .y_ready_o ( y_ready ),
    .x_ready_o ( x_ready ),
    .w_ready_o ( w_ready ),
    .z_row_o   ( z_row   ),
    .z_valid_o ( z_valid )
  );

  redmule_z_writer i_z_writer (
    .clk_i     ( clk_i          ),
    .rst_i     ( rst_i          ),
    .start_i   ( start          ),
    .base_i    ( z_base         ),
    .row_i     ( z_row          ),
    .valid_i   ( z_valid        ),
    .req_ack_i ( cl_ack[CL_Z]   ),
    .ready_o   ( z_ready        ),
    .req_o     ( cl_req[CL_Z]   ),
    .addr_o    ( cl_addr[CL_Z]  ),
    .wdata_o   ( cl_wdata[CL_Z] ),
    .z_done_o  ( z_done         )
  );

  redmule_mem_arbiter i_mem_arbiter (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .cl_req_i    ( cl_req      ),
    .cl_we_i     ( cl_we       ),
    .cl_addr_i   ( cl_addr     ),
    .cl_wdata_i  ( cl_wdata    ),
    .cl_ack_o    ( cl_ack      ),
    .cl_rdata_o  ( cl_rdata    ),
    .mem_req_o   ( mem_req_o   ),
    .mem_we_o    ( mem_we_o    ),
    .mem_addr_o  ( mem_addr_o  ),
    .mem_wdata_o ( mem_wdata_o ),
    .mem_ack_i   ( mem_ack_i   ),
    .mem_rdata_i ( mem_rdata_i )
  );

endmodule

// ==== source/redmule_z_writer.sv ====
module redmule_z_writer (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           start_i,
  input  logic [redmule_pkg::ADDR_W-1:0] base_i,
  input  redmule_pkg::mem_word_u         row_i,
  input  logic                           valid_i,
  input  logic                           req_ack_i,
  output logic                           ready_o,
  output logic                           req_o,
  output logic [redmule_pkg::ADDR_W-1:0] addr_o,
  output redmule_pkg::mem_word_u         wdata_o,
  output logic                           z_done_o
);
  import redmule_pkg::*;

  logic [ADDR_W-1:0]        base_q;
  logic [$clog2(LANES)-1:0] row_q;
  mem_word_u                wdata_q;
  logic                     wait_q;
  logic                     req_q;
  logic                     drop_q;
  logic                     done_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wait_q <= 1'b0;
      req_q  <= 1'b0;
      drop_q <= 1'b0;
      done_q <= 1'b0;
      row_q  <= '0;
      base_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        base_q <= base_i;
        row_q  <= '0;
        wait_q <= 1'b1;
      end else if (wait_q && valid_i) begin
        wait_q <= 1'b0;
        req_q  <= 1'b1;
      end else if (req_q && req_ack_i) begin
        req_q  <= 1'b0;
        drop_q <= 1'b1;
      end else if (drop_q && !req_ack_i) begin
        // Write is complete once ack has fallen
        drop_q <= 1'b0;
        row_q  <= row_q + 1'b1;
        if (row_q == $clog2(LANES)'(LANES - 1)) begin
          done_q <= 1'b1;
        end else begin
          wait_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wait_q && valid_i) begin
      wdata_q.lane <= row_i.lane;
    end
  end

  assign ready_o  = wait_q;
  assign req_o    = req_q;
  assign addr_o   = base_q + ADDR_W'(row_q);
  assign wdata_o  = wdata_q;
  assign z_done_o = done_q;

endmodule
